// File: src/commit_pkg.sv
// Shared definitions for the commit stage
// Issue number type, default sizes and the selector state encoding

package commit_pkg;

	////////////////////
	// Issue numbering
	////////////////////

	// Issue numbers wrap modulo 2**ISSUE_W
	localparam int ISSUE_W = 4;

	typedef logic [ISSUE_W-1:0] issue_no_t;

	////////////////////
	// Default sizes
	////////////////////

	localparam int DEFAULT_NUM_LANES = 4;

	// DEPTH_S + DEPTH_V must not exceed 2**ISSUE_W
	localparam int DEFAULT_DEPTH_S = 4;
	localparam int DEFAULT_DEPTH_V = 4;

	// Source of the last commit
	typedef enum logic [1:0] {
		IDLE     = 2'd0,
		COMMIT_S = 2'd1,
		COMMIT_V = 2'd2
	} commit_state_t;

endpackage

// File: src/scalar_reorder_buffer.sv
// Reorder buffer for the scalar back end
// Circular queue of issue numbers with one done flag per entry

`timescale 1ns/1ps

module scalar_reorder_buffer #(
	parameter int DEPTH_S = commit_pkg::DEFAULT_DEPTH_S
) (
	input logic clock,
	input logic reset,
	input logic store,
	input commit_pkg::issue_no_t store_no,
	input logic done,
	input commit_pkg::issue_no_t done_no,
	input logic pop,
	output logic ready,
	output logic head_valid,
	output commit_pkg::issue_no_t head_no,
	output logic head_done
);
	import commit_pkg::*;

	localparam int PTR_W = (DEPTH_S > 1) ? $clog2(DEPTH_S) : 1;
	localparam int CNT_W = $clog2(DEPTH_S + 1);

	issue_no_t entry_no [DEPTH_S];
	logic [DEPTH_S-1:0] entry_valid;
	logic [DEPTH_S-1:0] entry_done;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic full;

	assign full = (count == CNT_W'(DEPTH_S));

	// A pop frees the head in time for a refill at the same edge
	assign ready = ~full | pop;

	assign head_valid = entry_valid[rd_ptr];
	assign head_no = entry_no[rd_ptr];
	assign head_done = entry_done[rd_ptr];

	////////////////////
	// Entry flags and pointers
	////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			entry_valid <= '0;
			entry_done <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			// Completions may hit any valid entry, not only the head
			for (int i = 0; i < DEPTH_S; i++) begin
				if (done && entry_valid[i] && (entry_no[i] == done_no)) begin
					entry_done[i] <= 1'b1;
				end
			end
			if (pop) begin
				entry_valid[rd_ptr] <= 1'b0;
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH_S - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// Store after pop so a refill of the freed slot wins
			if (store) begin
				entry_valid[wr_ptr] <= 1'b1;
				entry_done[wr_ptr] <= 1'b0;
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH_S - 1)) ? '0 : wr_ptr + 1'b1;
			end
			case ({store, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Issue numbers
	always_ff @(posedge clock) begin
		if (store) begin
			entry_no[wr_ptr] <= store_no;
		end
	end

endmodule

// File: src/vector_reorder_buffer.sv
// Reorder buffer for the vector unit
// Circular queue of issue numbers with a lane mask per entry
// Lane-done reports accumulate until every enabled lane has finished

`timescale 1ns/1ps

module vector_reorder_buffer #(
	parameter int DEPTH_V = commit_pkg::DEFAULT_DEPTH_V,
	parameter int NUM_LANES = commit_pkg::DEFAULT_NUM_LANES
) (
	input logic clock,
	input logic reset,
	input logic store,
	input commit_pkg::issue_no_t store_no,
	input logic [NUM_LANES-1:0] lane_enable,
	input logic [NUM_LANES-1:0] done,
	input commit_pkg::issue_no_t done_no,
	input logic pop,
	output logic ready,
	output logic head_valid,
	output commit_pkg::issue_no_t head_no,
	output logic head_done
);
	import commit_pkg::*;

	localparam int PTR_W = (DEPTH_V > 1) ? $clog2(DEPTH_V) : 1;
	localparam int CNT_W = $clog2(DEPTH_V + 1);

	issue_no_t entry_no [DEPTH_V];
	logic [NUM_LANES-1:0] lane_mask [DEPTH_V];
	logic [NUM_LANES-1:0] lane_seen [DEPTH_V];
	logic [DEPTH_V-1:0] entry_valid;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic full;

	assign full = (count == CNT_W'(DEPTH_V));
	assign ready = ~full | pop;

	assign head_valid = entry_valid[rd_ptr];
	assign head_no = entry_no[rd_ptr];

	// Done once each enabled lane has reported
	// An empty mask makes the entry done right away
	assign head_done = &(lane_seen[rd_ptr] | ~lane_mask[rd_ptr]);

	////////////////////
	// Entry flags and pointers
	////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			entry_valid <= '0;
			for (int i = 0; i < DEPTH_V; i++) begin
				lane_seen[i] <= '0;
			end
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			// Collect lane reports for the matching entry
			for (int i = 0; i < DEPTH_V; i++) begin
				if (entry_valid[i] && (entry_no[i] == done_no)) begin
					lane_seen[i] <= lane_seen[i] | done;
				end
			end
			if (pop) begin
				entry_valid[rd_ptr] <= 1'b0;
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH_V - 1)) ? '0 : rd_ptr + 1'b1;
			end
			if (store) begin
				entry_valid[wr_ptr] <= 1'b1;
				lane_seen[wr_ptr] <= '0;
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH_V - 1)) ? '0 : wr_ptr + 1'b1;
			end
			case ({store, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	////////////////////
	// Entry payload
	////////////////////

	// Lane mask is sampled when the issue is accepted
	always_ff @(posedge clock) begin
		if (store) begin
			entry_no[wr_ptr] <= store_no;
			lane_mask[wr_ptr] <= lane_enable;
		end
	end

endmodule

// File: src/commit_select.sv
// Issue and commit sequencing
// Issue counter with store routing, commit counter and head selection

`timescale 1ns/1ps

module commit_select (
	input logic clock,
	input logic reset,
	input logic issue_valid,
	input logic issue_vector,
	input logic ready_s,
	input logic ready_v,
	input logic head_valid_s,
	input logic head_done_s,
	input commit_pkg::issue_no_t head_no_s,
	input logic head_valid_v,
	input logic head_done_v,
	input commit_pkg::issue_no_t head_no_v,
	output logic store_s,
	output logic store_v,
	output commit_pkg::issue_no_t issue_no,
	output logic pop_s,
	output logic pop_v,
	output logic commit_valid,
	output commit_pkg::issue_no_t commit_no,
	output logic commit_vector
);
	import commit_pkg::*;

	issue_no_t issue_count;
	issue_no_t commit_count;
	commit_state_t state;
	logic take_s;
	logic take_v;

	////////////////////
	// Issue side
	////////////////////

	// Issue to a full buffer is dropped and keeps its number
	assign store_s = issue_valid & ~issue_vector & ready_s;
	assign store_v = issue_valid & issue_vector & ready_v;
	assign issue_no = issue_count;

	////////////////////
	// Commit side
	////////////////////

	// Only the head carrying the commit count may retire
	assign take_s = head_valid_s & head_done_s & (head_no_s == commit_count);
	assign take_v = head_valid_v & head_done_v & (head_no_v == commit_count);
	assign pop_s = take_s;
	assign pop_v = take_v & ~take_s;

	assign commit_valid = (state != IDLE);
	assign commit_vector = (state == COMMIT_V);

	always_ff @(posedge clock) begin
		if (reset) begin
			issue_count <= '0;
			commit_count <= '0;
			state <= IDLE;
		end else begin
			if (store_s || store_v) begin
				issue_count <= issue_count + issue_no_t'(1);
			end
			if (pop_s || pop_v) begin
				commit_count <= commit_count + issue_no_t'(1);
			end
			if (pop_s) begin
				state <= COMMIT_S;
			end else if (pop_v) begin
				state <= COMMIT_V;
			end else begin
				state <= IDLE;
			end
		end
	end

	// Number of the entry just retired
	always_ff @(posedge clock) begin
		if (pop_s || pop_v) begin
			commit_no <= commit_count;
		end
	end

endmodule

// File: src/commit_unit.sv
// Commit stage top level
// Scalar and vector reorder buffers side by side with the commit selector

`timescale 1ns/1ps

module commit_unit #(
	parameter int DEPTH_S = commit_pkg::DEFAULT_DEPTH_S,
	parameter int DEPTH_V = commit_pkg::DEFAULT_DEPTH_V,
	parameter int NUM_LANES = commit_pkg::DEFAULT_NUM_LANES
) (
	input logic clock,
	input logic reset,
	input logic issue_valid,
	input logic issue_vector,
	input logic [NUM_LANES-1:0] lane_enable,
	input logic scalar_done,
	input commit_pkg::issue_no_t scalar_done_no,
	input logic [NUM_LANES-1:0] vector_done,
	input commit_pkg::issue_no_t vector_done_no,
	output logic issue_ready_s,
	output logic issue_ready_v,
	output commit_pkg::issue_no_t issue_no,
	output logic commit_valid,
	output commit_pkg::issue_no_t commit_no,
	output logic commit_vector
);
	import commit_pkg::*;

	logic store_s;
	logic store_v;
	logic pop_s;
	logic pop_v;
	logic head_valid_s;
	logic head_done_s;
	issue_no_t head_no_s;
	logic head_valid_v;
	logic head_done_v;
	issue_no_t head_no_v;

	// Entries in flight need distinct issue numbers
	if (DEPTH_S + DEPTH_V > (1 << ISSUE_W)) begin : g_depth_check
		$error("DEPTH_S + DEPTH_V exceeds the issue number range");
	end

	////////////////////
	// Reorder buffers
	////////////////////
	scalar_reorder_buffer #(
		.DEPTH_S(DEPTH_S)
	) u_rob_s (
		.clock(clock),
		.reset(reset),
		.store(store_s),
		.store_no(issue_no),
		.done(scalar_done),
		.done_no(scalar_done_no),
		.pop(pop_s),
		.ready(issue_ready_s),
		.head_valid(head_valid_s),
		.head_no(head_no_s),
		.head_done(head_done_s)
	);

	vector_reorder_buffer #(
		.DEPTH_V(DEPTH_V),
		.NUM_LANES(NUM_LANES)
	) u_rob_v (
		.clock(clock),
		.reset(reset),
		.store(store_v),
		.store_no(issue_no),
		.lane_enable(lane_enable),
		.done(vector_done),
		.done_no(vector_done_no),
		.pop(pop_v),
		.ready(issue_ready_v),
		.head_valid(head_valid_v),
		.head_no(head_no_v),
		.head_done(head_done_v)
	);

	////////////////////
	// Commit selection
	////////////////////
	commit_select u_select (
		.clock(clock),
		.reset(reset),
		.issue_valid(issue_valid),
		.issue_vector(issue_vector),
		.ready_s(issue_ready_s),
		.ready_v(issue_ready_v),
		.head_valid_s(head_valid_s),
		.head_done_s(head_done_s),
		.head_no_s(head_no_s),
		.head_valid_v(head_valid_v),
		.head_done_v(head_done_v),
		.head_no_v(head_no_v),
		.store_s(store_s),
		.store_v(store_v),
		.issue_no(issue_no),
		.pop_s(pop_s),
		.pop_v(pop_v),
		.commit_valid(commit_valid),
		.commit_no(commit_no),
		.commit_vector(commit_vector)
	);

endmodule

// File: testbench/commit_unit_properties.sv
// Concurrent checks on the commit unit ports
// Bound into every commit_unit instance

`timescale 1ns/1ps

module commit_unit_properties (
	input logic clock,
	input logic reset,
	input logic issue_valid,
	input logic issue_vector,
	input logic issue_ready_s,
	input logic issue_ready_v,
	input logic commit_valid,
	input commit_pkg::issue_no_t commit_no
);
	import commit_pkg::*;

	logic accepted;
	int outstanding;
	logic seen_commit;
	issue_no_t last_no;

	assign accepted = issue_valid & (issue_vector ? issue_ready_v : issue_ready_s);

	// Issues in flight and the last retired number
	always_ff @(posedge clock) begin
		if (reset) begin
			outstanding <= 0;
			seen_commit <= 1'b0;
			last_no <= '0;
		end else begin
			outstanding <= outstanding + int'(accepted) - int'(commit_valid);
			if (commit_valid) begin
				seen_commit <= 1'b1;
				last_no <= commit_no;
			end
		end
	end

	commit_needs_issue: assert property (@(posedge clock) disable iff (reset)
		commit_valid |-> outstanding > 0)
		else $error("commit_valid high with no issue in flight");

	// Retired numbers step by one, wrapping at 16
	commit_in_sequence: assert property (@(posedge clock) disable iff (reset)
		commit_valid && seen_commit |-> commit_no == last_no + issue_no_t'(1))
		else $error("commit_no %0d does not follow %0d", commit_no, last_no);

	first_commit_zero: assert property (@(posedge clock) disable iff (reset)
		commit_valid && !seen_commit |-> commit_no == '0)
		else $error("first commit after reset is not number zero");

endmodule

bind commit_unit commit_unit_properties u_properties (
	.clock(clock),
	.reset(reset),
	.issue_valid(issue_valid),
	.issue_vector(issue_vector),
	.issue_ready_s(issue_ready_s),
	.issue_ready_v(issue_ready_v),
	.commit_valid(commit_valid),
	.commit_no(commit_no)
);

// File: testbench/commit_unit_tb.sv
// Testbench for the commit unit
// Directed fill and random issue/completion stimulus against a reference queue
// Cycle-accurate commit and ready checks, watchdog and closing result line

`timescale 1ns/1ps

module commit_unit_tb;
	import commit_pkg::*;

	localparam int DEPTH_S = DEFAULT_DEPTH_S;
	localparam int DEPTH_V = DEFAULT_DEPTH_V;
	localparam int NUM_LANES = DEFAULT_NUM_LANES;
	localparam int RANDOM_ISSUES = 200;
	localparam int PLANNED_ISSUES = DEPTH_S + DEPTH_V + 3 + RANDOM_ISSUES;

	logic clock;
	logic reset;
	logic issue_valid;
	logic issue_vector;
	logic [NUM_LANES-1:0] lane_enable;
	logic scalar_done;
	issue_no_t scalar_done_no;
	logic [NUM_LANES-1:0] vector_done;
	issue_no_t vector_done_no;
	logic issue_ready_s;
	logic issue_ready_v;
	issue_no_t issue_no;
	logic commit_valid;
	issue_no_t commit_no;
	logic commit_vector;

	// Reference queue of accepted entries not yet popped, oldest first
	int ref_no [$];
	bit ref_vec [$];
	logic [NUM_LANES-1:0] ref_mask [$];
	logic [NUM_LANES-1:0] ref_seen [$];

	int seed = 32'h5a8b;
	int errors = 0;
	int accepted = 0;
	int commits = 0;
	int next_no = 0;
	int base = 0;
	bit exp_cv = 1'b0;
	int exp_cno = 0;
	bit exp_cvec = 1'b0;

	commit_unit #(
		.DEPTH_S(DEPTH_S),
		.DEPTH_V(DEPTH_V),
		.NUM_LANES(NUM_LANES)
	) DUT (
		.clock(clock),
		.reset(reset),
		.issue_valid(issue_valid),
		.issue_vector(issue_vector),
		.lane_enable(lane_enable),
		.scalar_done(scalar_done),
		.scalar_done_no(scalar_done_no),
		.vector_done(vector_done),
		.vector_done_no(vector_done_no),
		.issue_ready_s(issue_ready_s),
		.issue_ready_v(issue_ready_v),
		.issue_no(issue_no),
		.commit_valid(commit_valid),
		.commit_no(commit_no),
		.commit_vector(commit_vector)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	task automatic report_mismatch(string name, int expected, int actual);
		errors++;
		$display("mismatch at %0t: %s expected %0d, DUT %0d", $time, name, expected, actual);
	endtask

	// Every enabled lane reported (scalar entries use lane 0)
	function automatic bit entry_complete(int k);
		return &(ref_seen[k] | ~ref_mask[k]);
	endfunction

	////////////////////
	// Reference model
	////////////////////

	// Runs between edges, so registers and inputs are stable
	task automatic model_step();
		bit pop_now;
		bit take;
		bit exp_ready_s;
		bit exp_ready_v;
		int occ_s;
		int occ_v;
		assert (commit_valid == exp_cv)
			else report_mismatch("commit_valid", int'(exp_cv), int'(commit_valid));
		if (exp_cv && commit_valid) begin
			commits++;
			assert (int'(commit_no) == exp_cno)
				else report_mismatch("commit_no", exp_cno, int'(commit_no));
			assert (commit_vector == exp_cvec)
				else report_mismatch("commit_vector", int'(exp_cvec), int'(commit_vector));
		end
		assert (int'(issue_no) == next_no)
			else report_mismatch("issue_no", next_no, int'(issue_no));
		// Oldest entry retires at the next edge once complete
		pop_now = (ref_no.size() > 0) && entry_complete(0);
		occ_s = 0;
		occ_v = 0;
		foreach (ref_vec[k]) begin
			if (ref_vec[k]) begin
				occ_v++;
			end else begin
				occ_s++;
			end
		end
		exp_ready_s = (occ_s < DEPTH_S) || (pop_now && !ref_vec[0]);
		exp_ready_v = (occ_v < DEPTH_V) || (pop_now && ref_vec[0]);
		assert (issue_ready_s == exp_ready_s)
			else report_mismatch("issue_ready_s", int'(exp_ready_s), int'(issue_ready_s));
		assert (issue_ready_v == exp_ready_v)
			else report_mismatch("issue_ready_v", int'(exp_ready_v), int'(issue_ready_v));
		// Completions land before the entry being stored this cycle exists
		foreach (ref_no[k]) begin
			if (scalar_done && !ref_vec[k] && ref_no[k] == int'(scalar_done_no)) begin
				ref_seen[k] = ref_seen[k] | NUM_LANES'(1);
			end
			if (ref_vec[k] && ref_no[k] == int'(vector_done_no)) begin
				ref_seen[k] = ref_seen[k] | vector_done;
			end
		end
		take = issue_valid && (issue_vector ? exp_ready_v : exp_ready_s);
		if (take) begin
			ref_no.push_back(next_no);
			ref_vec.push_back(issue_vector);
			ref_mask.push_back(issue_vector ? lane_enable : NUM_LANES'(1));
			ref_seen.push_back(NUM_LANES'(0));
			next_no = (next_no + 1) % (1 << ISSUE_W);
			accepted++;
		end
		if (pop_now) begin
			exp_cno = ref_no.pop_front();
			exp_cvec = ref_vec.pop_front();
			ref_mask.delete(0);
			ref_seen.delete(0);
		end
		exp_cv = pop_now;
	endtask

	always @(negedge clock) begin
		if (!reset) begin
			model_step();
		end
	end

	////////////////////
	// Stimulus
	////////////////////

	// Drive point 1 ns after the rising edge, strobes cleared
	task automatic next_cycle();
		@(posedge clock);
		#1;
		issue_valid = 1'b0;
		scalar_done = 1'b0;
		vector_done = '0;
	endtask

	task automatic issue_one(bit vec, logic [NUM_LANES-1:0] mask);
		issue_valid = 1'b1;
		issue_vector = vec;
		lane_enable = mask;
	endtask

	// All missing lanes, or the scalar strobe, for entry k
	task automatic complete_entry(int k);
		if (ref_vec[k]) begin
			vector_done = ref_mask[k] & ~ref_seen[k];
			vector_done_no = issue_no_t'(ref_no[k]);
		end else begin
			scalar_done = 1'b1;
			scalar_done_no = issue_no_t'(ref_no[k]);
		end
	endtask

	task automatic complete_random();
		int k;
		logic [NUM_LANES-1:0] lanes;
		if (ref_no.size() == 0) begin
			return;
		end
		k = int'($unsigned($random(seed)) % ref_no.size());
		if (entry_complete(k)) begin
			return;
		end
		lanes = NUM_LANES'($random(seed)) & ref_mask[k] & ~ref_seen[k];
		if (!ref_vec[k] || lanes == '0) begin
			complete_entry(k);
		end else begin
			// Partial lane report
			vector_done = lanes;
			vector_done_no = issue_no_t'(ref_no[k]);
		end
	endtask

	initial begin
		reset = 1'b1;
		issue_valid = 1'b0;
		issue_vector = 1'b0;
		lane_enable = '0;
		scalar_done = 1'b0;
		scalar_done_no = '0;
		vector_done = '0;
		vector_done_no = '0;
		repeat (10) @(posedge clock);
		#1;
		reset = 1'b0;

		// Fill both buffers past depth with completions withheld
		for (int i = 0; i < DEPTH_S + 2; i++) begin
			next_cycle();
			issue_one(1'b0, '0);
		end
		for (int i = 0; i < DEPTH_V + 1; i++) begin
			next_cycle();
			issue_one(1'b1, (i == 0) ? NUM_LANES'(0) : (NUM_LANES'($random(seed)) | 1'b1));
		end
		repeat (4) next_cycle();

		// Youngest first, so nothing retires until the oldest reports
		for (int k = ref_no.size() - 1; k >= 0; k--) begin
			next_cycle();
			complete_entry(k);
		end
		while (ref_no.size() != 0) begin
			next_cycle();
		end

		// Mixed random traffic
		base = accepted;
		while (accepted - base < RANDOM_ISSUES) begin
			next_cycle();
			if ($random(seed) % 4 != 0) begin
				issue_one($random(seed) % 2 != 0, NUM_LANES'($random(seed)));
			end
			complete_random();
			complete_random();
		end
		while (ref_no.size() != 0) begin
			next_cycle();
			complete_random();
			complete_random();
		end
		repeat (3) next_cycle();

		assert (commits == accepted) else report_mismatch("commit count", accepted, commits);
		$display("issues %0d, commits %0d, errors %0d", accepted, commits, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	// Watchdog
	initial begin
		repeat (PLANNED_ISSUES * 400) @(posedge clock);
		$display("timeout: run did not finish within %0d cycles", PLANNED_ISSUES * 400);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: src.f
src/commit_pkg.sv
src/scalar_reorder_buffer.sv
src/vector_reorder_buffer.sv
src/commit_select.sv
src/commit_unit.sv
testbench/commit_unit_properties.sv
testbench/commit_unit_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the commit unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -f src.f --top-module commit_unit_tb \
	-Mdir "$BUILD_DIR" -o commit_unit_sim
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

"./$BUILD_DIR/commit_unit_sim" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "RESULT: FAIL" "$LOG_FILE"; then
	exit 1
fi
if ! grep -q "RESULT: PASS" "$LOG_FILE"; then
	echo "no result line found in $LOG_FILE"
	exit 1
fi
exit 0
